// ==== files.f ====
hdl/adc_map_pkg.sv
hdl/adc_stream_pkg.sv
hdl/reg_capture.sv
hdl/frame_builder.sv
hdl/config_channel.sv
hdl/adc_interface.sv
verification/adc_interface_checks.sv
verification/adc_interface_tb.sv

// ==== Bender.yml ====
package:
  name: adc_interface

sources:
  - hdl/adc_map_pkg.sv
  - hdl/adc_stream_pkg.sv
  - hdl/reg_capture.sv
  - hdl/frame_builder.sv
  - hdl/config_channel.sv
  - hdl/adc_interface.sv
  - target: test
    files:
      - verification/adc_interface_checks.sv
      - verification/adc_interface_tb.sv

// ==== verification/adc_interface_tb.sv ====
`default_nettype none

module adc_interface_tb import adc_map_pkg::*, adc_stream_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int WRITE_COUNT = 63; // Host writes over all tests
	localparam int FRAME_WORDS = 56; // Frame words delivered over all tests
	localparam int WATCHDOG_CYCLES = (WRITE_COUNT + FRAME_WORDS) * 4 + 200;

	typedef enum {sdc_stream, cmc_stream, buffc_stream, bufft_stream} stream_t;

	logic clk = 1'b0;
	logic rst;
	logic [MEM_SIZE-1:0] fresh_bits;
	word_t [MEM_SIZE-1:0] read_resps;
	logic state_rdy;
	word_t [SDC_SAMPLES-1:0] sdc_data;
	logic sdc_valid;
	logic sdc_ready;
	word_t [CHAN_SAMPLES-1:0] cmc_data;
	logic cmc_valid;
	logic cmc_ready;
	buff_config_t buffc_data;
	logic buffc_valid;
	logic buffc_ready;
	ts_t bufft_data;
	logic bufft_valid;
	logic bufft_last;
	logic bufft_ready;
	mem_wr_t ts_wr;

	word_t [MEM_SIZE-1:0] mem; // Host memory that feeds read_resps once per batch
	logic [MEM_SIZE-1:0] batch_mask;
	logic [31:0] lcg_state = 32'h765aabc5;
	logic [8*16-1:0] test_name;
	int errors;
	int errors_at_start;
	int tests_passed = 0;
	int tests_failed = 0;
	int stall;
	word_t first_cfg;

	always #(CLK_PERIOD / 2) clk = ~clk;

	adc_interface u_adc_interface (.*);

	adc_interface_checks u_checks (.*);

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic stage_write(input mem_addr_t addr, input word_t value);
		mem[addr] = value;
		batch_mask[addr] = 1'b1;
	endtask

	// Present one batch, drop the strobes on the snapshot edge, then wait for the drain
	task automatic send_batch();
		@(posedge clk);
		read_resps <= mem;
		fresh_bits <= batch_mask;
		batch_mask = '0;
		do @(posedge clk); while (!state_rdy);
		fresh_bits <= '0;
		do @(posedge clk); while (!state_rdy);
	endtask

	task automatic write_frame(input mem_addr_t base, input int samples, input mem_addr_t commit);
		for (int i = 0; i < samples; i++) begin
			stage_write(base + mem_addr_t'(i), word_t'(next_rand() >> 16));
		end
		send_batch();
		stage_write(commit, 16'h0001); // Any nonzero word commits
		send_batch();
	endtask

	task automatic wait_handshake(input stream_t stream);
		logic hit;
		do begin
			@(posedge clk);
			case (stream)
				sdc_stream: hit = sdc_valid && sdc_ready;
				cmc_stream: hit = cmc_valid && cmc_ready;
				buffc_stream: hit = buffc_valid && buffc_ready;
				default: hit = bufft_valid && bufft_ready;
			endcase
		end while (!hit);
	endtask

	task automatic begin_test(input logic [8*16-1:0] name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		repeat (3) @(posedge clk); // Write-back checks land a cycle late
		if (errors == errors_at_start) begin
			$display("pass %0s", test_name);
			tests_passed++;
		end else begin
			$display("fail %0s: %0d check(s) failed", test_name, errors - errors_at_start);
			tests_failed++;
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		fresh_bits = '0;
		read_resps = '0;
		sdc_ready = 1'b1;
		cmc_ready = 1'b1;
		buffc_ready = 1'b0;
		bufft_data = '0;
		bufft_valid = 1'b0;
		bufft_last = 1'b0;
		mem = '0;
		batch_mask = '0;
		test_name = "reset";
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		begin_test("sdc_frame");
		write_frame(SDC_BASE_ID, SDC_SAMPLES, SDC_VALID_ID);
		wait_handshake(sdc_stream);
		end_test();

		begin_test("cmc_stall");
		@(posedge clk);
		cmc_ready <= 1'b0;
		write_frame(CHAN_MUX_BASE_ID, CHAN_SAMPLES, CHAN_MUX_VALID_ID);
		do @(posedge clk); while (!cmc_valid);
		stall = 1 + int'(next_rand() % 8);
		repeat (stall) @(posedge clk);
		cmc_ready <= 1'b1;
		wait_handshake(cmc_stream);
		end_test();

		begin_test("ts_gate");
		@(posedge clk);
		bufft_data <= next_rand();
		bufft_valid <= 1'b1;
		bufft_last <= 1'b1;
		repeat (4) @(posedge clk); // The timestamp has to wait until a config word is taken
		stage_write(BUFF_CONFIG_ID, word_t'(next_rand() >> 16));
		send_batch();
		buffc_ready <= 1'b1;
		wait_handshake(buffc_stream);
		buffc_ready <= 1'b0;
		wait_handshake(bufft_stream);
		bufft_valid <= 1'b0;
		bufft_last <= 1'b0;
		end_test();

		begin_test("cfg_latest");
		first_cfg = word_t'(next_rand() >> 16);
		stage_write(BUFF_CONFIG_ID, first_cfg);
		send_batch();
		// The second word always differs from the first in the low bits
		stage_write(BUFF_CONFIG_ID, first_cfg ^ word_t'(1 + next_rand() % 15));
		send_batch();
		buffc_ready <= 1'b1;
		wait_handshake(buffc_stream);
		repeat (3) @(posedge clk); // Ready stays up to expose a stray second transfer
		buffc_ready <= 1'b0;
		end_test();

		begin_test("sdc_pipeline");
		@(posedge clk);
		sdc_ready <= 1'b0;
		write_frame(SDC_BASE_ID, SDC_SAMPLES, SDC_VALID_ID); // Frame A
		write_frame(SDC_BASE_ID, SDC_SAMPLES, SDC_VALID_ID); // Frame B parks behind A
		repeat (3) @(posedge clk);
		sdc_ready <= 1'b1;
		wait_handshake(sdc_stream);
		wait_handshake(sdc_stream);
		end_test();

		$display("%0d tests passed, %0d tests failed, %0d failed checks",
			tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/adc_interface_checks.sv ====
`default_nettype none

module adc_interface_checks import adc_map_pkg::*, adc_stream_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [8*16-1:0] test_name,
	input logic [MEM_SIZE-1:0] fresh_bits,
	input word_t [MEM_SIZE-1:0] read_resps,
	input logic state_rdy,
	input word_t [SDC_SAMPLES-1:0] sdc_data,
	input logic sdc_valid,
	input logic sdc_ready,
	input word_t [CHAN_SAMPLES-1:0] cmc_data,
	input logic cmc_valid,
	input logic cmc_ready,
	input buff_config_t buffc_data,
	input logic buffc_valid,
	input logic buffc_ready,
	input ts_t bufft_data,
	input logic bufft_valid,
	input logic bufft_ready,
	input mem_wr_t ts_wr,
	output int errors
);

	timeunit 1ns;
	timeprecision 1ps;

	word_t [SDC_SAMPLES-1:0] sdc_stage; // Model of the builder's staging array
	word_t [CHAN_SAMPLES-1:0] cmc_stage;
	word_t [SDC_SAMPLES-1:0] sdc_q[$]; // Committed frames still to be transferred
	word_t [CHAN_SAMPLES-1:0] cmc_q[$];
	word_t [SDC_SAMPLES-1:0] sdc_head;
	word_t [CHAN_SAMPLES-1:0] cmc_head;
	int sdc_count;
	int cmc_count;
	buff_config_t cfg_exp;
	logic cfg_pend;
	logic armed_exp;
	ts_t ts_exp;
	logic snapshot;

	assign snapshot = state_rdy && (fresh_bits != '0); // Host words are taken on this edge

	initial errors = 0;

	always @(posedge clk) begin
		if (rst) begin
			sdc_q.delete();
			cmc_q.delete();
			sdc_head <= '0;
			cmc_head <= '0;
			sdc_count <= 0;
			cmc_count <= 0;
			cfg_pend <= 1'b0;
			armed_exp <= 1'b0;
		end else begin
			if (sdc_valid && sdc_ready && sdc_q.size() > 0) begin
				void'(sdc_q.pop_front());
			end
			if (cmc_valid && cmc_ready && cmc_q.size() > 0) begin
				void'(cmc_q.pop_front());
			end
			if (buffc_valid && buffc_ready) begin
				cfg_pend <= 1'b0;
			end
			// A timestamp disarms, a config transfer arms
			if (bufft_valid && bufft_ready) begin
				armed_exp <= 1'b0;
				ts_exp <= bufft_data;
			end else if (buffc_valid && buffc_ready) begin
				armed_exp <= 1'b1;
			end
			if (snapshot) begin
				for (int i = 0; i < MEM_SIZE; i++) begin
					if (fresh_bits[i] && i >= int'(SDC_BASE_ID) &&
						i < int'(SDC_BASE_ID) + SDC_SAMPLES) begin
						sdc_stage[i - int'(SDC_BASE_ID)] = read_resps[i];
					end
					if (fresh_bits[i] && i >= int'(CHAN_MUX_BASE_ID) &&
						i < int'(CHAN_MUX_BASE_ID) + CHAN_SAMPLES) begin
						cmc_stage[i - int'(CHAN_MUX_BASE_ID)] = read_resps[i];
					end
				end
				if (fresh_bits[SDC_VALID_ID] && read_resps[SDC_VALID_ID] != '0) begin
					sdc_q.push_back(sdc_stage); // Window words sit below their commit address
				end
				if (fresh_bits[CHAN_MUX_VALID_ID] && read_resps[CHAN_MUX_VALID_ID] != '0) begin
					cmc_q.push_back(cmc_stage);
				end
				if (fresh_bits[BUFF_CONFIG_ID]) begin
					cfg_exp <= buff_config_t'(read_resps[BUFF_CONFIG_ID]);
					cfg_pend <= 1'b1;
				end
			end
			sdc_head <= (sdc_q.size() > 0) ? sdc_q[0] : '0;
			cmc_head <= (cmc_q.size() > 0) ? cmc_q[0] : '0;
			sdc_count <= sdc_q.size();
			cmc_count <= cmc_q.size();
		end
	end

	sdc_frame_match: assert property (@(posedge clk) disable iff (rst)
		sdc_valid && sdc_ready |-> sdc_count > 0 && sdc_data == sdc_head)
	else begin
		$display("mismatch %0s: sdc frame expected %h actual %h", test_name,
			$sampled(sdc_head), $sampled(sdc_data));
		errors = errors + 1;
	end

	cmc_frame_match: assert property (@(posedge clk) disable iff (rst)
		cmc_valid && cmc_ready |-> cmc_count > 0 && cmc_data == cmc_head)
	else begin
		$display("mismatch %0s: cmc frame expected %h actual %h", test_name,
			$sampled(cmc_head), $sampled(cmc_data));
		errors = errors + 1;
	end

	sdc_hold: assert property (@(posedge clk) disable iff (rst)
		sdc_valid && !sdc_ready |=> sdc_valid && $stable(sdc_data))
	else begin
		$display("%0s: sdc frame changed or vanished while sdc_ready was low", test_name);
		errors = errors + 1;
	end

	cmc_hold: assert property (@(posedge clk) disable iff (rst)
		cmc_valid && !cmc_ready |=> cmc_valid && $stable(cmc_data))
	else begin
		$display("%0s: cmc frame changed or vanished while cmc_ready was low", test_name);
		errors = errors + 1;
	end

	cfg_match: assert property (@(posedge clk) disable iff (rst)
		buffc_valid && buffc_ready |-> cfg_pend && buffc_data == cfg_exp)
	else begin
		$display("mismatch %0s: buffc expected %h actual %h (config pending %b)", test_name,
			$sampled(cfg_exp), $sampled(buffc_data), $sampled(cfg_pend));
		errors = errors + 1;
	end

	ts_gate: assert property (@(posedge clk) disable iff (rst)
		bufft_ready == armed_exp)
	else begin
		$display("mismatch %0s: bufft_ready expected %b actual %b", test_name,
			$sampled(armed_exp), $sampled(bufft_ready));
		errors = errors + 1;
	end

	ts_write_back: assert property (@(posedge clk) disable iff (rst)
		bufft_valid && bufft_ready |=>
			ts_wr.valid && ts_wr.addr == BUFF_TIMESTAMP_ID && ts_wr.data == ts_exp)
	else begin
		$display("mismatch %0s: ts_wr expected %h at %0d actual %h at %0d", test_name,
			$sampled(ts_exp), BUFF_TIMESTAMP_ID, $sampled(ts_wr.data), $sampled(ts_wr.addr));
		errors = errors + 1;
	end

	ts_single_pulse: assert property (@(posedge clk) disable iff (rst)
		!(bufft_valid && bufft_ready) |=> !ts_wr.valid)
	else begin
		$display("%0s: ts_wr pulsed without a timestamp transfer", test_name);
		errors = errors + 1;
	end

	rdy_after_reset: assert property (@(posedge clk) $fell(rst) |-> state_rdy)
	else begin
		$display("%0s: state_rdy was low after reset", test_name);
		errors = errors + 1;
	end

	rdy_drops: assert property (@(posedge clk) disable iff (rst) snapshot |=> !state_rdy)
	else begin
		$display("%0s: state_rdy stayed high after a snapshot", test_name);
		errors = errors + 1;
	end

	rdy_before_batch: assert property (@(posedge clk) disable iff (rst)
		$rose(|fresh_bits) |-> state_rdy)
	else begin
		$display("%0s: a new batch found state_rdy low", test_name);
		errors = errors + 1;
	end

endmodule

`default_nettype wire

// ==== hdl/adc_interface.sv ====
`default_nettype none

module adc_interface import adc_map_pkg::*, adc_stream_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [MEM_SIZE-1:0] fresh_bits,
	input word_t [MEM_SIZE-1:0] read_resps,
	output logic state_rdy,
	output word_t [SDC_SAMPLES-1:0] sdc_data,
	output logic sdc_valid,
	input logic sdc_ready,
	output word_t [CHAN_SAMPLES-1:0] cmc_data,
	output logic cmc_valid,
	input logic cmc_ready,
	output buff_config_t buffc_data,
	output logic buffc_valid,
	input logic buffc_ready,
	input ts_t bufft_data,
	input logic bufft_valid,
	input logic bufft_last,
	output logic bufft_ready,
	output mem_wr_t ts_wr
);

	wr_event_t wr_event; // Shared by all second-stage blocks

	reg_capture u_reg_capture (
		.clk(clk),
		.rst(rst),
		.fresh_bits(fresh_bits),
		.read_resps(read_resps),
		.state_rdy(state_rdy),
		.wr_event(wr_event)
	);

	frame_builder #(
		.SAMPLES(SDC_SAMPLES),
		.BASE_ID(SDC_BASE_ID),
		.VALID_ID(SDC_VALID_ID)
	) u_sdc_builder (
		.clk(clk),
		.rst(rst),
		.wr_event(wr_event),
		.data(sdc_data),
		.valid(sdc_valid),
		.ready(sdc_ready)
	);

	frame_builder #(
		.SAMPLES(CHAN_SAMPLES),
		.BASE_ID(CHAN_MUX_BASE_ID),
		.VALID_ID(CHAN_MUX_VALID_ID)
	) u_cmc_builder (
		.clk(clk),
		.rst(rst),
		.wr_event(wr_event),
		.data(cmc_data),
		.valid(cmc_valid),
		.ready(cmc_ready)
	);

	config_channel u_config_channel (
		.clk(clk),
		.rst(rst),
		.wr_event(wr_event),
		.buffc_data(buffc_data),
		.buffc_valid(buffc_valid),
		.buffc_ready(buffc_ready),
		.bufft_data(bufft_data),
		.bufft_valid(bufft_valid),
		.bufft_last(bufft_last),
		.bufft_ready(bufft_ready),
		.ts_wr(ts_wr)
	);

endmodule

`default_nettype wire

// ==== hdl/config_channel.sv ====
`default_nettype none

module config_channel import adc_map_pkg::*, adc_stream_pkg::*; (
	input logic clk,
	input logic rst,
	input wr_event_t wr_event,
	output buff_config_t buffc_data,
	output logic buffc_valid,
	input logic buffc_ready,
	input ts_t bufft_data,
	input logic bufft_valid,
	input logic bufft_last,
	output logic bufft_ready,
	output mem_wr_t ts_wr
);

	typedef enum logic {
		disarmed,
		armed
	} arm_state_t;

	arm_state_t state;
	logic cfg_event;
	logic buffc_fire;
	logic bufft_fire;
	logic ts_valid;
	ts_t ts_data;

	assign cfg_event = wr_event.valid && (wr_event.addr == BUFF_CONFIG_ID);
	assign buffc_fire = buffc_valid && buffc_ready;
	assign bufft_fire = bufft_valid && bufft_ready;
	assign bufft_ready = (state == armed); // Timestamps only for a configured buffer

	always_ff @(posedge clk) begin
		if (rst) begin
			buffc_valid <= 1'b0;
			state <= disarmed;
			ts_valid <= 1'b0;
		end else begin
			if (cfg_event) begin
				buffc_valid <= 1'b1;
			end else if (buffc_fire) begin
				buffc_valid <= 1'b0;
			end

			case (state)
				disarmed: if (buffc_fire) state <= armed;
				armed: if (bufft_fire) state <= disarmed; // One timestamp per config
				default: state <= disarmed;
			endcase

			ts_valid <= bufft_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (cfg_event) begin
			buffc_data <= buff_config_t'(wr_event.data); // Latest write wins
		end
		if (bufft_fire) begin
			ts_data <= bufft_data;
		end
	end

	assign ts_wr = '{valid: ts_valid, addr: BUFF_TIMESTAMP_ID, data: ts_data};

	single_word_packet: assert property (@(posedge clk) disable iff (rst)
		bufft_valid |-> bufft_last);

	// Only a newer config write may change a waiting word
	buffc_stable: assert property (@(posedge clk) disable iff (rst)
		buffc_valid && !buffc_ready && !cfg_event |=> buffc_valid && $stable(buffc_data));

endmodule

`default_nettype wire

// ==== hdl/frame_builder.sv ====
`default_nettype none

module frame_builder import adc_map_pkg::*, adc_stream_pkg::*; #(
	parameter int SAMPLES = SDC_SAMPLES,
	parameter mem_addr_t BASE_ID = SDC_BASE_ID,
	parameter mem_addr_t VALID_ID = SDC_VALID_ID
) (
	input logic clk,
	input logic rst,
	input wr_event_t wr_event,
	output word_t [SAMPLES-1:0] data,
	output logic valid,
	input logic ready
);

	word_t [SAMPLES-1:0] stage;
	word_t [SAMPLES-1:0] held; // Snapshot of a commit that found the output full
	logic pend;
	mem_addr_t offset;
	logic in_window;
	logic commit;
	logic fire;
	logic promote;
	logic load_now;
	logic park;

	assign offset = wr_event.addr - BASE_ID;
	assign in_window = wr_event.valid && (wr_event.addr >= BASE_ID) &&
		(int'(wr_event.addr) < int'(BASE_ID) + SAMPLES);
	assign commit = wr_event.valid && (wr_event.addr == VALID_ID) && (wr_event.data != '0);

	assign fire = valid && ready;
	assign promote = pend && fire; // Parked frame moves up behind the handshake
	assign load_now = commit && !pend && (!valid || ready);
	assign park = commit && !load_now;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
			pend <= 1'b0;
		end else begin
			if (load_now || promote) begin
				valid <= 1'b1;
			end else if (fire) begin
				valid <= 1'b0;
			end

			if (park) begin
				pend <= 1'b1; // A second park replaces the first
			end else if (promote) begin
				pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_window) begin
			stage[offset] <= wr_event.data;
		end
		if (park) begin
			held <= stage;
		end
		if (load_now) begin
			data <= stage;
		end else if (promote) begin
			data <= held;
		end
	end

	frame_stable: assert property (@(posedge clk) disable iff (rst)
		valid && !ready |=> valid && $stable(data));

	pend_needs_valid: assert property (@(posedge clk) disable iff (rst)
		pend |-> valid);

endmodule

`default_nettype wire

// ==== hdl/reg_capture.sv ====
`default_nettype none

module reg_capture import adc_map_pkg::*, adc_stream_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [MEM_SIZE-1:0] fresh_bits,
	input word_t [MEM_SIZE-1:0] read_resps,
	output logic state_rdy,
	output wr_event_t wr_event
);

	logic [MEM_SIZE-1:0] pending;
	word_t [MEM_SIZE-1:0] shadow;
	logic snapshot;
	mem_addr_t next_idx;
	logic ev_valid;
	mem_addr_t ev_addr;
	word_t ev_data;

	assign state_rdy = (pending == '0);
	assign snapshot = state_rdy && (|fresh_bits); // Host holds its words until this cycle

	// Lowest pending address wins
	always_comb begin
		next_idx = '0;
		for (int i = MEM_SIZE - 1; i >= 0; i--) begin
			if (pending[i]) begin
				next_idx = mem_addr_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
			ev_valid <= 1'b0;
		end else begin
			ev_valid <= 1'b0;
			if (snapshot) begin
				pending <= fresh_bits;
			end else if (!state_rdy) begin
				ev_valid <= 1'b1;
				pending[next_idx] <= 1'b0; // Issued this cycle
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < MEM_SIZE; i++) begin
			if (snapshot && fresh_bits[i]) begin
				shadow[i] <= read_resps[i];
			end
		end
		ev_addr <= next_idx;
		ev_data <= shadow[next_idx];
	end

	assign wr_event = '{valid: ev_valid, addr: ev_addr, data: ev_data};

	// An issued address must have been in the mask on the edge that issued it
	issue_was_pending: assert property (@(posedge clk) disable iff (rst)
		wr_event.valid |->
			|($past(pending) & ({{(MEM_SIZE-1){1'b0}}, 1'b1} << wr_event.addr)));

endmodule

`default_nettype wire

// ==== hdl/adc_stream_pkg.sv ====
`default_nettype none

package adc_stream_pkg;

	import adc_map_pkg::*;

	// One host write after serialization by the capture stage
	typedef struct packed {
		logic valid;
		mem_addr_t addr;
		word_t data;
	} wr_event_t;

	// Write pulse back into the memory map
	typedef struct packed {
		logic valid;
		mem_addr_t addr;
		ts_t data;
	} mem_wr_t;

	localparam int BUFF_CONFIG_WIDTH = 4;
	typedef logic [BUFF_CONFIG_WIDTH-1:0] buff_config_t; // Low bits of the config word

endpackage

`default_nettype wire

// ==== hdl/adc_map_pkg.sv ====
`default_nettype none

package adc_map_pkg;

	localparam int WORD_WIDTH = 16;
	typedef logic [WORD_WIDTH-1:0] word_t; // One memory-map word

	localparam int MEM_SIZE = 32;
	localparam int ADDR_WIDTH = $clog2(MEM_SIZE);
	typedef logic [ADDR_WIDTH-1:0] mem_addr_t;

	localparam int SDC_SAMPLES = 16;
	localparam int CHAN_SAMPLES = 8;

	// Each frame window is followed by its commit address
	localparam mem_addr_t SDC_BASE_ID = 5'd0;
	localparam mem_addr_t SDC_VALID_ID = 5'd16;
	localparam mem_addr_t CHAN_MUX_BASE_ID = 5'd17;
	localparam mem_addr_t CHAN_MUX_VALID_ID = 5'd25;
	localparam mem_addr_t BUFF_CONFIG_ID = 5'd26;
	localparam mem_addr_t BUFF_TIMESTAMP_ID = 5'd27; // Written back by the subsystem

	localparam int TS_WIDTH = 32;
	typedef logic [TS_WIDTH-1:0] ts_t;

endpackage

`default_nettype wire
